/* src.f */
+incdir+hdl
hdl/cpu_mem_pkg.sv
hdl/cpu_dcache.sv
hdl/cpu_mem_stage.sv
hdl/cpu_mem_subsystem.sv
dv/tb_bus_ram.sv
dv/cpu_mem_assert.sv
dv/tb_cpu_mem.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_cpu_mem -o sim_cpu_mem

./obj_dir/sim_cpu_mem > sim.log 2>&1
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
	exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
	exit 1
fi
exit 0

/* dv/tb_cpu_mem.sv */
`default_nettype none
`timescale 1ns/100ps

`include "cpu_mem_macros.svh"

module tb_cpu_mem;

	logic                      i_clock;
	logic                      i_reset;
	cpu_mem_pkg::mem_req_t     i_req;
	logic                      i_bus_ready;
	logic [31:0]               i_bus_rdata;
	cpu_mem_pkg::mem_result_t  o_result;
	logic                      o_stall;
	cpu_mem_pkg::bus_req_t     o_bus;
	logic [31:0]               o_hit_count;
	logic [31:0]               o_miss_count;

	logic [31:0]              lfsr = 32'd68314;
	logic [31:0]              shadow [0:255];
	logic [`CPU_TAG_BITS-1:0] tag_count;
	int                       test_errors;
	int                       pass_count;
	int                       fail_count;

	cpu_mem_subsystem DUT (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_req        (i_req),
		.i_bus_ready  (i_bus_ready),
		.i_bus_rdata  (i_bus_rdata),
		.o_result     (o_result),
		.o_stall      (o_stall),
		.o_bus        (o_bus),
		.o_hit_count  (o_hit_count),
		.o_miss_count (o_miss_count)
	);

	tb_bus_ram u_ram (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_bus   (o_bus),
		.o_ready (i_bus_ready),
		.o_rdata (i_bus_rdata)
	);

	initial begin
		i_clock = 1'b0;
		forever #50 i_clock = ~i_clock;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [31:0] extract_load(input logic [31:0] word, input logic [1:0] off,
			input logic [2:0] width, input logic sgn);
		logic [7:0]  b;
		logic [15:0] h;
		b = word[{off, 3'b000} +: 8];
		h = word[{off, 3'b000} +: 16];
		if (width == `MEM_WIDTH_BYTE)
			return {{24{sgn & b[7]}}, b};
		if (width == `MEM_WIDTH_HALF)
			return {{16{sgn & h[15]}}, h};
		return word;
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
		test_errors++;
	endtask

	task automatic end_run();
		$display("Tests passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	endtask

	task automatic end_test(input string name);
		if (test_errors == 0) begin
			pass_count++;
			$display("%s: passed", name);
		end else begin
			fail_count++;
			$display("%s: failed with %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	task automatic wait_retire(input logic [`CPU_TAG_BITS-1:0] tag, input logic mem_op,
			output logic saw_bus);
		int  cycles;
		logic done;
		cycles  = 0;
		done    = 1'b0;
		saw_bus = 1'b0;
		while (!done && cycles < 200) begin
			@(negedge i_clock);
			if (o_bus.request)
				saw_bus = 1'b1;
			if (o_result.tag == tag)
				done = 1'b1;
			// Stall covers a memory access until its tag retires
			assert (o_stall == (mem_op && !done))
				else report_mismatch("stall", 32'(o_stall), 32'(mem_op && !done));
			cycles++;
		end
		if (!done) begin
			$display("Timeout: instruction with tag %0d did not retire in 200 cycles", tag);
			test_errors++;
			end_test("timeout");
			end_run();
		end
	endtask

	task automatic execute(input logic rd_en, input logic wr_en, input logic [2:0] width,
			input logic sgn, input logic [31:0] addr, input logic [31:0] rd_value,
			output logic [31:0] result_rd, output logic saw_bus);
		cpu_mem_pkg::mem_req_t r;
		logic [31:0]           bits;
		r = '0;
		tag_count = tag_count + 1'b1;
		r.tag = tag_count;
		random_bits(5, bits);
		r.inst_rd = bits[4:0];
		random_bits(32, bits);
		r.pc_next   = bits;
		r.rd        = rd_value;
		r.read      = rd_en;
		r.write     = wr_en;
		r.width     = width;
		r.is_signed = sgn;
		r.address   = addr;
		@(posedge i_clock);
		i_req <= r;
		wait_retire(r.tag, rd_en || wr_en, saw_bus);
		assert (o_result.inst_rd == r.inst_rd)
			else report_mismatch("inst_rd", 32'(o_result.inst_rd), 32'(r.inst_rd));
		assert (o_result.pc_next == r.pc_next)
			else report_mismatch("pc_next", o_result.pc_next, r.pc_next);
		result_rd = o_result.rd;
	endtask

	task automatic do_load(input logic [7:0] idx, input logic [1:0] off, input logic [2:0] width,
			input logic sgn);
		logic [31:0] got;
		logic [31:0] exp;
		logic        saw_bus;
		execute(1'b1, 1'b0, width, sgn, {22'd0, idx, off}, 32'd0, got, saw_bus);
		exp = extract_load(shadow[idx], off, width, sgn);
		assert (got == exp) else report_mismatch("load data", got, exp);
	endtask

	task automatic do_store(input logic [7:0] idx, input logic [1:0] off, input logic [2:0] width,
			input logic [31:0] data);
		logic [31:0] got;
		logic        saw_bus;
		execute(1'b0, 1'b1, width, 1'b0, {22'd0, idx, off}, data, got, saw_bus);
		if (width == `MEM_WIDTH_BYTE)
			shadow[idx][{off, 3'b000} +: 8] = data[7:0];
		else if (width == `MEM_WIDTH_HALF)
			shadow[idx][{off, 3'b000} +: 16] = data[15:0];
		else
			shadow[idx] = data;
	endtask

	task automatic apply_reset();
		@(posedge i_clock);
		i_req   <= '0;
		i_reset <= 1'b1;
		repeat (3) @(posedge i_clock);
		i_reset <= 1'b0;
		@(posedge i_clock);
		tag_count = '0;
	endtask

	initial begin
		logic [31:0] bits;
		logic [31:0] got;
		logic [31:0] h0;
		logic [31:0] m0;
		logic [7:0]  idx;
		logic [7:0]  other;
		logic        saw_bus;
		i_reset     = 1'b1;
		i_req       = '0;
		tag_count   = '0;
		test_errors = 0;
		pass_count  = 0;
		fail_count  = 0;
		apply_reset();
		for (int i = 0; i < 256; i++)
			shadow[i] = u_ram.mem[i];

		// Word store then load, RAM mirrors the shadow
		for (int n = 0; n < 20; n++) begin
			random_bits(8, bits);
			idx = bits[7:0];
			random_bits(32, bits);
			do_store(idx, 2'd0, `MEM_WIDTH_WORD, bits);
			do_load(idx, 2'd0, `MEM_WIDTH_WORD, 1'b0);
		end
		for (int i = 0; i < 256; i++) begin
			assert (u_ram.mem[i] == shadow[i])
				else report_mismatch("bus RAM word", u_ram.mem[i], shadow[i]);
		end
		end_test("word store and load");

		for (int n = 0; n < 6; n++) begin
			random_bits(8, bits);
			idx = bits[7:0];
			for (int off = 0; off < 4; off++) begin
				random_bits(8, bits);
				do_store(idx, off[1:0], `MEM_WIDTH_BYTE, bits);
				do_load(idx, 2'd0, `MEM_WIDTH_WORD, 1'b0);
			end
			for (int off = 0; off < 4; off += 2) begin
				random_bits(16, bits);
				do_store(idx, off[1:0], `MEM_WIDTH_HALF, bits);
				do_load(idx, 2'd0, `MEM_WIDTH_WORD, 1'b0);
			end
		end
		end_test("sub-word stores");

		for (int n = 0; n < 8; n++) begin
			random_bits(8, bits);
			idx = bits[7:0];
			for (int s = 0; s < 2; s++) begin
				for (int off = 0; off < 4; off++)
					do_load(idx, off[1:0], `MEM_WIDTH_BYTE, s[0]);
				do_load(idx, 2'd0, `MEM_WIDTH_HALF, s[0]);
				do_load(idx, 2'd2, `MEM_WIDTH_HALF, s[0]);
			end
		end
		end_test("sub-word loads");

		for (int n = 0; n < 10; n++) begin
			random_bits(32, bits);
			execute(1'b0, 1'b0, `MEM_WIDTH_WORD, 1'b0, 32'd0, bits, got, saw_bus);
			assert (got == bits) else report_mismatch("pass-through rd", got, bits);
			assert (!saw_bus) else begin
				$display("Pass-through instruction raised a bus request at %0t", $time);
				test_errors++;
			end
		end
		end_test("pass-through");

		// Evict the line first, then count hits and misses
		random_bits(8, bits);
		idx   = bits[7:0];
		other = idx + 8'd64;
		do_load(other, 2'd0, `MEM_WIDTH_WORD, 1'b0);
		h0 = o_hit_count;
		m0 = o_miss_count;
		do_load(idx, 2'd0, `MEM_WIDTH_WORD, 1'b0);
		assert (o_miss_count == m0 + 1) else report_mismatch("miss count", o_miss_count, m0 + 1);
		for (int n = 0; n < 3; n++)
			do_load(idx, 2'd0, `MEM_WIDTH_WORD, 1'b0);
		assert (o_hit_count == h0 + 3) else report_mismatch("hit count", o_hit_count, h0 + 3);
		do_load(other, 2'd0, `MEM_WIDTH_WORD, 1'b0);
		assert (o_miss_count == m0 + 2) else report_mismatch("miss count", o_miss_count, m0 + 2);
		end_test("hit and miss counters");

		apply_reset();
		assert (o_hit_count == 0) else report_mismatch("hit count after reset", o_hit_count, 0);
		assert (o_miss_count == 0) else report_mismatch("miss count after reset", o_miss_count, 0);
		assert (!o_stall) else report_mismatch("stall after reset", 32'(o_stall), 0);
		assert (o_result == '0) else report_mismatch("result rd after reset", o_result.rd, 0);
		do_load(other, 2'd0, `MEM_WIDTH_WORD, 1'b0);
		assert (o_miss_count == 1) else report_mismatch("miss after reset", o_miss_count, 1);
		assert (o_hit_count == 0) else report_mismatch("hit after reset", o_hit_count, 0);
		end_test("mid-run reset");

		end_run();
	end

endmodule

bind cpu_mem_stage cpu_mem_assert u_assert (
	.i_clock       (i_clock),
	.i_reset       (i_reset),
	.i_result      (o_result),
	.i_stall       (o_stall),
	.i_bus         (o_bus),
	.i_bus_ready   (i_bus_ready),
	.i_cache_port  (cache_port),
	.i_cache_ready (cache_ready)
);

`default_nettype wire

/* dv/cpu_mem_assert.sv */
`default_nettype none
`timescale 1ns/100ps

module cpu_mem_assert (
	input wire                           i_clock,
	input wire                           i_reset,
	input wire cpu_mem_pkg::mem_result_t i_result,
	input wire                           i_stall,
	input wire cpu_mem_pkg::bus_req_t    i_bus,
	input wire                           i_bus_ready,
	input wire cpu_mem_pkg::cache_port_t i_cache_port,
	input wire                           i_cache_ready
);

	// Bus request held with a stable address until ready
	a_bus_hold: assert property (@(posedge i_clock) disable iff (i_reset)
		i_bus.request && !i_bus_ready |=> i_bus.request && $stable(i_bus.address))
		else $error("bus request dropped or address moved before ready");

	a_cache_hold: assert property (@(posedge i_clock) disable iff (i_reset)
		i_cache_port.request && !i_cache_ready |=> i_cache_port.request)
		else $error("cache request dropped before ready");

	a_reset_stall: assert property (@(posedge i_clock)
		i_reset |=> !i_stall)
		else $error("stall high in the cycle after reset");

	// Stall and result hold until the cache answers
	a_stall_rule: assert property (@(posedge i_clock) disable iff (i_reset)
		i_stall && !i_cache_ready |=> i_stall && $stable(i_result))
		else $error("stall dropped or result moved before the cache answered");

endmodule

`default_nettype wire

/* dv/tb_bus_ram.sv */
`default_nettype none
`timescale 1ns/100ps

`include "cpu_mem_macros.svh"

module tb_bus_ram (
	input  wire                        i_clock,
	input  wire                        i_reset,
	input  wire cpu_mem_pkg::bus_req_t i_bus,
	output logic                       o_ready,
	output logic [31:0]                o_rdata
);

	logic [31:0] mem [0:255];
	logic [7:0]  delay_count;
	logic [7:0]  word_index;

	assign word_index = i_bus.address[9:2];

	// Fill word built from the whole index
	initial begin
		logic [7:0] a;
		for (int i = 0; i < 256; i++) begin
			a = i[7:0];
			mem[i] = {~a, a ^ 8'h3c, a, a ^ 8'ha5};
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			delay_count <= '0;
			o_ready     <= 1'b0;
		end else begin
			o_ready <= 1'b0;
			// Request is still high in the ready cycle
			if (i_bus.request && !o_ready) begin
				if (delay_count == 8'(`BUS_RAM_DELAY - 1)) begin
					delay_count <= '0;
					o_ready     <= 1'b1;
					o_rdata     <= mem[word_index];
					if (i_bus.rw) begin
						mem[word_index] <= i_bus.wdata;
					end
				end else begin
					delay_count <= delay_count + 8'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/cpu_mem_subsystem.sv */
`default_nettype none
`timescale 1ns/100ps

module cpu_mem_subsystem (
	input  wire                        i_clock,
	input  wire                        i_reset,
	input  wire cpu_mem_pkg::mem_req_t i_req,
	input  wire                        i_bus_ready,
	input  wire [31:0]                 i_bus_rdata,
	output cpu_mem_pkg::mem_result_t   o_result,
	output logic                       o_stall,
	output cpu_mem_pkg::bus_req_t      o_bus,
	output logic [31:0]                o_hit_count,
	output logic [31:0]                o_miss_count
);

	// Memory stage with its data cache
	cpu_mem_stage u_mem_stage (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_req        (i_req),
		.i_bus_ready  (i_bus_ready),
		.i_bus_rdata  (i_bus_rdata),
		.o_result     (o_result),
		.o_stall      (o_stall),
		.o_bus        (o_bus),
		.o_hit_count  (o_hit_count),
		.o_miss_count (o_miss_count)
	);

endmodule

`default_nettype wire

/* hdl/cpu_mem_stage.sv */
`default_nettype none
`timescale 1ns/100ps

`include "cpu_mem_macros.svh"

module cpu_mem_stage (
	input  wire                        i_clock,
	input  wire                        i_reset,
	input  wire cpu_mem_pkg::mem_req_t i_req,
	input  wire                        i_bus_ready,
	input  wire [31:0]                 i_bus_rdata,
	output cpu_mem_pkg::mem_result_t   o_result,
	output logic                       o_stall,
	output cpu_mem_pkg::bus_req_t      o_bus,
	output logic [31:0]                o_hit_count,
	output logic [31:0]                o_miss_count
);

	localparam logic [1:0] ST_IDLE           = 2'd0;
	localparam logic [1:0] ST_RMW_READ       = 2'd1;
	localparam logic [1:0] ST_RMW_REREQ      = 2'd2;
	localparam logic [1:0] ST_RMW_WAIT_WRITE = 2'd3;

	logic [1:0] state;

	logic        port_rw;
	logic        port_request;
	logic [31:0] port_wdata;

	cpu_mem_pkg::cache_port_t cache_port;
	logic                     cache_ready;
	logic [31:0]              cache_rdata;

	logic        new_inst;
	logic [1:0]  offset;
	logic [31:0] rdata_shifted;
	logic [31:0] load_value;
	logic [31:0] merged_word;

	cpu_dcache u_dcache (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_port       (cache_port),
		.i_bus_ready  (i_bus_ready),
		.i_bus_rdata  (i_bus_rdata),
		.o_ready      (cache_ready),
		.o_rdata      (cache_rdata),
		.o_bus        (o_bus),
		.o_hit_count  (o_hit_count),
		.o_miss_count (o_miss_count)
	);

	assign new_inst = i_req.tag != o_result.tag;
	assign o_stall  = new_inst && (i_req.read || i_req.write);

	// Cache works on whole words
	assign cache_port = '{
		rw:      port_rw,
		request: port_request,
		address: {i_req.address[31:2], 2'b00},
		wdata:   port_wdata
	};

	assign offset        = i_req.address[1:0];
	assign rdata_shifted = cache_rdata >> {offset, 3'b000};

	always_comb begin
		case (i_req.width)
			`MEM_WIDTH_BYTE:
				load_value = {{24{i_req.is_signed & rdata_shifted[7]}}, rdata_shifted[7:0]};
			`MEM_WIDTH_HALF:
				load_value = {{16{i_req.is_signed & rdata_shifted[15]}}, rdata_shifted[15:0]};
			default:
				load_value = cache_rdata;
		endcase
	end

	// Insert store data into the word read back
	always_comb begin
		merged_word = cache_rdata;
		if (i_req.width == `MEM_WIDTH_BYTE) begin
			merged_word[{offset, 3'b000} +: 8] = i_req.rd[7:0];
		end else begin
			case (offset)
				2'd0: merged_word = {cache_rdata[31:16], i_req.rd[15:0]};
				2'd2: merged_word = {i_req.rd[15:0], cache_rdata[15:0]};
				// odd halfword offsets unsupported
				default: merged_word = '0;
			endcase
		end
	end

	function automatic cpu_mem_pkg::mem_result_t retire(input logic [31:0] rd_value);
		cpu_mem_pkg::mem_result_t r;
		r.tag     = i_req.tag;
		r.inst_rd = i_req.inst_rd;
		r.rd      = rd_value;
		r.pc_next = i_req.pc_next;
		return r;
	endfunction

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state        <= ST_IDLE;
			port_rw      <= 1'b0;
			port_request <= 1'b0;
			o_result     <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (new_inst) begin
						if (i_req.read) begin
							port_request <= 1'b1;
							if (cache_ready) begin
								port_request <= 1'b0;
								o_result     <= retire(load_value);
							end
						end else if (i_req.write) begin
							port_request <= 1'b1;
							if (i_req.width == `MEM_WIDTH_WORD) begin
								port_rw <= 1'b1;
								if (cache_ready) begin
									port_rw      <= 1'b0;
									port_request <= 1'b0;
									o_result     <= retire(o_result.rd);
								end
							end else begin
								port_rw <= 1'b0;
								state   <= ST_RMW_READ;
							end
						end else begin
							o_result <= retire(i_req.rd);
						end
					end
				end

				ST_RMW_READ: begin
					if (cache_ready) begin
						port_request <= 1'b0;
						port_rw      <= 1'b1;
						state        <= ST_RMW_REREQ;
					end
				end

				// Request stays low for this one cycle
				ST_RMW_REREQ: begin
					port_request <= 1'b1;
					state        <= ST_RMW_WAIT_WRITE;
				end

				ST_RMW_WAIT_WRITE: begin
					if (cache_ready) begin
						port_request <= 1'b0;
						port_rw      <= 1'b0;
						o_result     <= retire(o_result.rd);
						state        <= ST_IDLE;
					end
				end

				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == ST_IDLE && new_inst && i_req.write) begin
			port_wdata <= i_req.rd;
		end else if (state == ST_RMW_READ && cache_ready) begin
			port_wdata <= merged_word;
		end
	end

endmodule

`default_nettype wire

/* hdl/cpu_dcache.sv */
`default_nettype none
`timescale 1ns/100ps

`include "cpu_mem_macros.svh"

module cpu_dcache (
	input  wire                          i_clock,
	input  wire                          i_reset,
	input  wire cpu_mem_pkg::cache_port_t i_port,
	input  wire                          i_bus_ready,
	input  wire [31:0]                   i_bus_rdata,
	output logic                         o_ready,
	output logic [31:0]                  o_rdata,
	output cpu_mem_pkg::bus_req_t        o_bus,
	output logic [31:0]                  o_hit_count,
	output logic [31:0]                  o_miss_count
);

	localparam int NUM_LINES = 1 << `DCACHE_INDEX_BITS;

	localparam logic ST_IDLE = 1'b0;
	localparam logic ST_BUS  = 1'b1;

	logic state;

	cpu_mem_pkg::dcache_tag_t tag_mem [0:NUM_LINES-1];
	logic [31:0]              data_mem [0:NUM_LINES-1];
	logic [NUM_LINES-1:0]     valid;

	cpu_mem_pkg::dcache_addr_u req_addr;

	logic hit;
	logic accept;
	logic read_hit;
	logic fill;
	logic bus_done;

	assign req_addr.raw = i_port.address;

	assign hit = valid[req_addr.fields.index] &&
		(tag_mem[req_addr.fields.index] == req_addr.fields.tag);

	// Ready is still high in the cycle the requester drops its request
	assign accept   = (state == ST_IDLE) && i_port.request && !o_ready;
	assign read_hit = accept && !i_port.rw && hit;

	assign bus_done = (state == ST_BUS) && i_bus_ready;
	assign fill     = bus_done && !o_bus.rw;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state        <= ST_IDLE;
			valid        <= '0;
			o_ready      <= 1'b0;
			o_bus        <= '0;
			o_hit_count  <= '0;
			o_miss_count <= '0;
		end else begin
			o_ready <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (read_hit) begin
						o_ready     <= 1'b1;
						o_hit_count <= o_hit_count + 32'd1;
					end else if (accept) begin
						// Miss, or any write: go out to the bus
						o_bus.rw      <= i_port.rw;
						o_bus.request <= 1'b1;
						o_bus.address <= req_addr.raw;
						o_bus.wdata   <= i_port.wdata;
						state         <= ST_BUS;
					end
				end

				ST_BUS: begin
					if (i_bus_ready) begin
						o_bus.request <= 1'b0;
						o_ready       <= 1'b1;
						state         <= ST_IDLE;
						if (!o_bus.rw) begin
							valid[req_addr.fields.index] <= 1'b1;
							o_miss_count <= o_miss_count + 32'd1;
						end
					end
				end

				default: state <= ST_IDLE;
			endcase
		end
	end

	// Line storage
	always_ff @(posedge i_clock) begin
		if (accept && i_port.rw && hit) begin
			data_mem[req_addr.fields.index] <= i_port.wdata;
		end
		if (fill) begin
			data_mem[req_addr.fields.index] <= i_bus_rdata;
			tag_mem[req_addr.fields.index]  <= req_addr.fields.tag;
		end
	end

	always_ff @(posedge i_clock) begin
		if (read_hit) begin
			o_rdata <= data_mem[req_addr.fields.index];
		end else if (bus_done) begin
			// Write completion returns the bus word too, nobody reads it
			o_rdata <= i_bus_rdata;
		end
	end

endmodule

`default_nettype wire

/* hdl/cpu_mem_pkg.sv */
`default_nettype none

`include "cpu_mem_macros.svh"

package cpu_mem_pkg;

	// One instruction from execute
	typedef struct packed {
		logic [`CPU_TAG_BITS-1:0] tag;
		logic [4:0]               inst_rd;
		logic [31:0]              rd;
		logic [31:0]              pc_next;
		logic                     read;
		logic                     write;
		logic [2:0]               width;
		logic                     is_signed;
		logic [31:0]              address;
	} mem_req_t;

	// Retired result toward writeback
	typedef struct packed {
		logic [`CPU_TAG_BITS-1:0] tag;
		logic [4:0]               inst_rd;
		logic [31:0]              rd;
		logic [31:0]              pc_next;
	} mem_result_t;

	typedef struct packed {
		logic        rw;
		logic        request;
		logic [31:0] address;
		logic [31:0] wdata;
	} cache_port_t;

	typedef struct packed {
		logic        rw;
		logic        request;
		logic [31:0] address;
		logic [31:0] wdata;
	} bus_req_t;

	typedef logic [31-`DCACHE_INDEX_BITS-2:0] dcache_tag_t;

	typedef struct packed {
		dcache_tag_t                   tag;
		logic [`DCACHE_INDEX_BITS-1:0] index;
		logic [1:0]                    offset;
	} dcache_addr_fields_t;

	// Same word seen as a bus address or as lookup fields
	typedef union packed {
		logic [31:0]         raw;
		dcache_addr_fields_t fields;
	} dcache_addr_u;

endpackage

`default_nettype wire

/* hdl/cpu_mem_macros.svh */
`ifndef CPU_MEM_MACROS_SVH
`define CPU_MEM_MACROS_SVH

// Instruction tag carried between execute and memory
`define CPU_TAG_BITS 4

// 64 one-word lines
`define DCACHE_INDEX_BITS 6

// Access width codes, 3-bit field
`define MEM_WIDTH_BYTE 3'd1
`define MEM_WIDTH_HALF 3'd2
`define MEM_WIDTH_WORD 3'd4

// Bus model latency in cycles
`define BUS_RAM_DELAY 2

`endif
